// File: ncpu_pkg.sv
// Shared widths, opcodes, instruction field positions and decoded-operation type for the core
`default_nettype none

package ncpu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths and reset state
   ////////////////////////////////////////////////////////////////////////////
   localparam int DW     = 32;          // Data word
   localparam int AW     = 32;          // Byte address
   localparam int IW     = 32;          // Instruction word
   localparam int REG_AW = 5;
   localparam int NUM_REGS = 2 ** REG_AW;

   localparam logic [AW-1:0] RESET_VECTOR = '0;
   localparam logic [AW-1:0] INSN_BYTES   = 4;   // PC step per instruction

   ////////////////////////////////////////////////////////////////////////////
   // Instruction field positions
   ////////////////////////////////////////////////////////////////////////////
   localparam int OPC_LSB   = 0;
   localparam int OPC_MSB   = 5;
   localparam int RD_LSB    = 6;
   localparam int RD_MSB    = 10;
   localparam int RS1_LSB   = 11;
   localparam int RS1_MSB   = 15;
   localparam int RS2_LSB   = 16;
   localparam int RS2_MSB   = 20;
   localparam int IMM16_LSB = 16;
   localparam int IMM16_MSB = 31;
   localparam int REL21_LSB = 11;      // Word offset for JMP_I
   localparam int REL21_MSB = 31;

   ////////////////////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////////////////////
   typedef logic [DW-1:0]     data_t;
   typedef logic [AW-1:0]     addr_t;
   typedef logic [IW-1:0]     insn_t;
   typedef logic [REG_AW-1:0] reg_addr_t;

   // Any other value decodes as a no-operation
   typedef enum logic [5:0] {
      OP_AND   = 6'd1,
      OP_AND_I,
      OP_OR,
      OP_OR_I,
      OP_XOR,
      OP_XOR_I,
      OP_LSL,
      OP_LSL_I,
      OP_LSR,
      OP_LSR_I,
      OP_ASR,
      OP_ASR_I,
      OP_ADD,
      OP_ADD_I,
      OP_SUB,
      OP_LDWU,
      OP_STW,
      OP_JMP_I                         // 18
   } opcode_e;

   // Result source in execute
   typedef enum logic [3:0] {
      LU_NONE,
      LU_AND,
      LU_OR,
      LU_XOR,
      LU_LSL,
      LU_LSR,
      LU_ASR,
      LU_ADD,
      LU_SUB,
      LU_LOAD
   } lu_op_e;

   // Decoded operation handed from decode to execute
   typedef struct packed {
      logic      valid;
      lu_op_e    lu_op;
      logic      use_imm;              // Operand 2 from imm instead of rs2
      data_t     imm;
      logic      mem_load;
      logic      mem_store;
      logic      wb_en;
      reg_addr_t wb_addr;
   } exec_op_t;

endpackage

`default_nettype wire

// File: ncpu_fetch.sv
// Fetch stage: program counter, instruction bus requests and the decode stage register
`timescale 1ns/1ps
`default_nettype none

module ncpu_fetch (
   input  wire logic            clk_i,
   input  wire logic            reset_i,
   input  wire logic            flow_i,         // Instruction accepted this cycle
   input  wire logic            dec_flow_i,     // Decode stage hands its word on
   input  wire logic            jmp_i,
   input  wire ncpu_pkg::addr_t jmp_offset_i,
   input  wire ncpu_pkg::insn_t insn_i,
   output ncpu_pkg::addr_t      iaddr_o,
   output logic                 ibus_rd_o,
   output ncpu_pkg::insn_t      dec_insn_o,
   output logic                 dec_valid_o
);

   ncpu_pkg::addr_t pc_q;
   ncpu_pkg::addr_t jmp_target_q;
   logic            jmp_pend_q;      // Jump left decode before its delay slot was fetched
   logic            ibus_rd_q;
   logic            take;
   logic            jmp_now;

   assign take    = flow_i & ibus_rd_q;
   assign jmp_now = dec_flow_i & jmp_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pc_q        <= ncpu_pkg::RESET_VECTOR;
         ibus_rd_q   <= 1'b0;
         jmp_pend_q  <= 1'b0;
         dec_valid_o <= 1'b0;
      end else begin
         ibus_rd_q <= 1'b1;
         if (take) begin
            // PC still points at the delay slot being accepted now
            if (jmp_now) begin
               pc_q <= pc_q + jmp_offset_i;
            end else if (jmp_pend_q) begin
               pc_q <= jmp_target_q;
            end else begin
               pc_q <= pc_q + ncpu_pkg::INSN_BYTES;
            end
            jmp_pend_q <= 1'b0;
         end else if (jmp_now) begin
            jmp_pend_q <= 1'b1;
         end
         if (take) begin
            dec_valid_o <= 1'b1;
         end else if (dec_flow_i) begin
            dec_valid_o <= 1'b0;             // Bubble on a slow instruction bus
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (take) dec_insn_o <= insn_i;
      if (jmp_now) jmp_target_q <= pc_q + jmp_offset_i;
   end

   assign iaddr_o   = pc_q;
   assign ibus_rd_o = ibus_rd_q;

endmodule

`default_nettype wire

// File: ncpu_decode.sv
// Decode stage: field split, opcode classification, immediates, jump request and execute register
`timescale 1ns/1ps
`default_nettype none

module ncpu_decode (
   input  wire logic                clk_i,
   input  wire logic                reset_i,
   input  wire logic                flow_i,
   input  wire ncpu_pkg::insn_t     insn_i,
   input  wire logic                valid_i,
   output ncpu_pkg::reg_addr_t      rs1_addr_o,
   output ncpu_pkg::reg_addr_t      rs2_addr_o,
   output logic                     jmp_o,
   output ncpu_pkg::addr_t          jmp_offset_o,
   output ncpu_pkg::exec_op_t       exec_op_o
);

   localparam int IMM_W = ncpu_pkg::IMM16_MSB - ncpu_pkg::IMM16_LSB + 1;
   localparam int REL_W = ncpu_pkg::REL21_MSB - ncpu_pkg::REL21_LSB + 1;

   logic [5:0]          f_opcode;
   ncpu_pkg::reg_addr_t f_rd;
   ncpu_pkg::reg_addr_t f_rs1;
   ncpu_pkg::reg_addr_t f_rs2;
   logic [IMM_W-1:0]    f_imm16;
   logic [REL_W-1:0]    f_rel21;
   ncpu_pkg::data_t     simm;
   ncpu_pkg::data_t     uimm;
   logic                imm_signed;
   logic                is_store;
   ncpu_pkg::exec_op_t  op_nxt;

   assign f_opcode = insn_i[ncpu_pkg::OPC_MSB:ncpu_pkg::OPC_LSB];
   assign f_rd     = insn_i[ncpu_pkg::RD_MSB:ncpu_pkg::RD_LSB];
   assign f_rs1    = insn_i[ncpu_pkg::RS1_MSB:ncpu_pkg::RS1_LSB];
   assign f_rs2    = insn_i[ncpu_pkg::RS2_MSB:ncpu_pkg::RS2_LSB];
   assign f_imm16  = insn_i[ncpu_pkg::IMM16_MSB:ncpu_pkg::IMM16_LSB];
   assign f_rel21  = insn_i[ncpu_pkg::REL21_MSB:ncpu_pkg::REL21_LSB];

   assign simm = {{(ncpu_pkg::DW-IMM_W){f_imm16[IMM_W-1]}}, f_imm16};
   assign uimm = {{(ncpu_pkg::DW-IMM_W){1'b0}}, f_imm16};

   assign imm_signed = (f_opcode == ncpu_pkg::OP_AND_I) | (f_opcode == ncpu_pkg::OP_XOR_I) |
                       (f_opcode == ncpu_pkg::OP_LDWU)  | (f_opcode == ncpu_pkg::OP_STW);
   assign is_store   = (f_opcode == ncpu_pkg::OP_STW);

   // Store data comes from the rd field through the second port
   assign rs1_addr_o = f_rs1;
   assign rs2_addr_o = is_store ? f_rd : f_rs2;

   // Word offset scaled to bytes
   assign jmp_o        = valid_i & (f_opcode == ncpu_pkg::OP_JMP_I);
   assign jmp_offset_o = {{(ncpu_pkg::AW-REL_W-2){f_rel21[REL_W-1]}}, f_rel21, 2'b00};

   ////////////////////////////////////////////////////////////////////////////
   // Opcode classification
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      op_nxt         = '0;
      op_nxt.valid   = valid_i;
      op_nxt.lu_op   = ncpu_pkg::LU_NONE;
      op_nxt.imm     = imm_signed ? simm : uimm;
      op_nxt.wb_addr = f_rd;
      case (f_opcode)
         ncpu_pkg::OP_AND,   ncpu_pkg::OP_AND_I: op_nxt.lu_op = ncpu_pkg::LU_AND;
         ncpu_pkg::OP_OR,    ncpu_pkg::OP_OR_I:  op_nxt.lu_op = ncpu_pkg::LU_OR;
         ncpu_pkg::OP_XOR,   ncpu_pkg::OP_XOR_I: op_nxt.lu_op = ncpu_pkg::LU_XOR;
         ncpu_pkg::OP_LSL,   ncpu_pkg::OP_LSL_I: op_nxt.lu_op = ncpu_pkg::LU_LSL;
         ncpu_pkg::OP_LSR,   ncpu_pkg::OP_LSR_I: op_nxt.lu_op = ncpu_pkg::LU_LSR;
         ncpu_pkg::OP_ASR,   ncpu_pkg::OP_ASR_I: op_nxt.lu_op = ncpu_pkg::LU_ASR;
         ncpu_pkg::OP_ADD,   ncpu_pkg::OP_ADD_I: op_nxt.lu_op = ncpu_pkg::LU_ADD;
         ncpu_pkg::OP_SUB:                       op_nxt.lu_op = ncpu_pkg::LU_SUB;
         ncpu_pkg::OP_LDWU: begin
            op_nxt.lu_op    = ncpu_pkg::LU_LOAD;
            op_nxt.mem_load = 1'b1;
         end
         ncpu_pkg::OP_STW:  op_nxt.mem_store = 1'b1;
         default:           op_nxt.lu_op     = ncpu_pkg::LU_NONE;  // JMP_I and no-ops
      endcase
      op_nxt.wb_en   = (op_nxt.lu_op != ncpu_pkg::LU_NONE);
      // Immediate forms and the memory ops take the immediate
      op_nxt.use_imm = (f_opcode == ncpu_pkg::OP_AND_I) | (f_opcode == ncpu_pkg::OP_OR_I) |
                       (f_opcode == ncpu_pkg::OP_XOR_I) | (f_opcode == ncpu_pkg::OP_LSL_I) |
                       (f_opcode == ncpu_pkg::OP_LSR_I) | (f_opcode == ncpu_pkg::OP_ASR_I) |
                       (f_opcode == ncpu_pkg::OP_ADD_I) | op_nxt.mem_load | op_nxt.mem_store;
   end

   // Execute stage register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         exec_op_o.valid <= 1'b0;
      end else if (flow_i) begin
         exec_op_o <= op_nxt;
      end
   end

endmodule

`default_nettype wire

// File: ncpu_regfile.sv
// Register file with 32 entries, two registered read ports, one write port and write-through
`timescale 1ns/1ps
`default_nettype none

module ncpu_regfile (
   input  wire logic                clk_i,
   input  wire logic                reset_i,
   input  wire logic                re_i,
   input  wire ncpu_pkg::reg_addr_t rs1_addr_i,
   input  wire ncpu_pkg::reg_addr_t rs2_addr_i,
   output ncpu_pkg::data_t          rs1_o,
   output ncpu_pkg::data_t          rs2_o,
   input  wire logic                rd_we_i,
   input  wire ncpu_pkg::reg_addr_t rd_addr_i,
   input  wire ncpu_pkg::data_t     rd_i
);

   ncpu_pkg::data_t rf [ncpu_pkg::NUM_REGS];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < ncpu_pkg::NUM_REGS; i++) begin
            rf[i] <= '0;
         end
      end else if (rd_we_i) begin
         rf[rd_addr_i] <= rd_i;
      end
   end

   // Writeback in the same cycle wins over the array
   always_ff @(posedge clk_i) begin
      if (re_i) begin
         rs1_o <= (rd_we_i && rd_addr_i == rs1_addr_i) ? rd_i : rf[rs1_addr_i];
         rs2_o <= (rd_we_i && rd_addr_i == rs2_addr_i) ? rd_i : rf[rs2_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: ncpu_execute.sv
// Execute stage: logic unit, adder, data bus access, result select and register writeback
`timescale 1ns/1ps
`default_nettype none

module ncpu_execute (
   input  wire ncpu_pkg::exec_op_t exec_op_i,
   input  wire ncpu_pkg::data_t    rs1_i,
   input  wire ncpu_pkg::data_t    rs2_i,
   input  wire ncpu_pkg::data_t    d_i,
   input  wire logic               dbus_rd_ready_i,
   input  wire logic               dbus_we_done_i,
   output ncpu_pkg::data_t         d_o,
   output ncpu_pkg::addr_t         addr_o,
   output logic                    dbus_rd_o,
   output logic                    dbus_we_o,
   output logic                    ready_o,
   output logic                    rd_we_o,
   output ncpu_pkg::reg_addr_t     rd_addr_o,
   output ncpu_pkg::data_t         rd_o
);

   localparam int DW = ncpu_pkg::DW;

   ncpu_pkg::data_t        op2;
   ncpu_pkg::data_t        shift_lsw;
   ncpu_pkg::data_t        shift_msw;
   logic [2*DW-1:0]        shift_wide;
   ncpu_pkg::data_t        shift_right;
   ncpu_pkg::data_t        lu_shift;
   ncpu_pkg::data_t        adder_op2;
   ncpu_pkg::data_t        adder_sum;
   logic                   is_lsl;
   logic                   is_sub;

   function automatic ncpu_pkg::data_t reverse_bits(input ncpu_pkg::data_t a);
      ncpu_pkg::data_t r;
      for (int i = 0; i < DW; i++) begin
         r[DW-1-i] = a[i];
      end
      return r;
   endfunction

   assign op2 = exec_op_i.use_imm ? exec_op_i.imm : rs2_i;

   ////////////////////////////////////////////////////////////////////////////
   // Shifter, one right shifter shared by all three shifts
   ////////////////////////////////////////////////////////////////////////////
   assign is_lsl      = (exec_op_i.lu_op == ncpu_pkg::LU_LSL);
   assign shift_lsw   = is_lsl ? reverse_bits(rs1_i) : rs1_i;
   assign shift_msw   = (exec_op_i.lu_op == ncpu_pkg::LU_ASR) ? {DW{rs1_i[DW-1]}} : '0;
   assign shift_wide  = {shift_msw, shift_lsw} >> op2[4:0];
   assign shift_right = shift_wide[DW-1:0];
   assign lu_shift    = is_lsl ? reverse_bits(shift_right) : shift_right;

   // Adder, also forms the load/store address
   assign is_sub    = (exec_op_i.lu_op == ncpu_pkg::LU_SUB);
   assign adder_op2 = is_sub ? ~op2 : op2;
   assign adder_sum = rs1_i + adder_op2 + {{(DW-1){1'b0}}, is_sub};

   ////////////////////////////////////////////////////////////////////////////
   // Data bus
   ////////////////////////////////////////////////////////////////////////////
   assign addr_o    = adder_sum;
   assign d_o       = rs2_i;                 // Register named by rd
   assign dbus_rd_o = exec_op_i.valid & exec_op_i.mem_load;
   assign dbus_we_o = exec_op_i.valid & exec_op_i.mem_store;

   // Stall while a memory access has not been answered
   assign ready_o = ~(dbus_rd_o & ~dbus_rd_ready_i) & ~(dbus_we_o & ~dbus_we_done_i);

   always_comb begin
      case (exec_op_i.lu_op)
         ncpu_pkg::LU_AND:  rd_o = rs1_i & op2;
         ncpu_pkg::LU_OR:   rd_o = rs1_i | op2;
         ncpu_pkg::LU_XOR:  rd_o = rs1_i ^ op2;
         ncpu_pkg::LU_LSL,
         ncpu_pkg::LU_LSR,
         ncpu_pkg::LU_ASR:  rd_o = lu_shift;
         ncpu_pkg::LU_ADD,
         ncpu_pkg::LU_SUB:  rd_o = adder_sum;
         ncpu_pkg::LU_LOAD: rd_o = d_i;
         default:           rd_o = '0;
      endcase
   end

   assign rd_we_o   = exec_op_i.valid & exec_op_i.wb_en & ready_o;
   assign rd_addr_o = exec_op_i.wb_addr;

endmodule

`default_nettype wire

// File: ncpu_core.sv
// Core top level; connects fetch, decode, register file and execute and derives stage flow
`timescale 1ns/1ps
`default_nettype none

module ncpu_core (
   input  wire logic            clk_i,
   input  wire logic            reset_i,
   input  wire ncpu_pkg::insn_t insn_i,
   input  wire logic            insn_ready_i,
   output ncpu_pkg::addr_t      iaddr_o,
   output logic                 ibus_rd_o,
   input  wire ncpu_pkg::data_t d_i,
   input  wire logic            dbus_rd_ready_i,
   input  wire logic            dbus_we_done_i,
   output ncpu_pkg::data_t      d_o,
   output ncpu_pkg::addr_t      addr_o,
   output logic                 dbus_rd_o,
   output logic                 dbus_we_o
);

   logic                exec_ready;
   logic                flow1;
   logic                flow2;
   logic                flow3;

   ncpu_pkg::insn_t     dec_insn;
   logic                dec_valid;
   logic                jmp;
   ncpu_pkg::addr_t     jmp_offset;
   ncpu_pkg::reg_addr_t rs1_addr;
   ncpu_pkg::reg_addr_t rs2_addr;
   ncpu_pkg::data_t     rs1;
   ncpu_pkg::data_t     rs2;
   ncpu_pkg::exec_op_t  exec_op;
   logic                rd_we;
   ncpu_pkg::reg_addr_t rd_addr;
   ncpu_pkg::data_t     rd;

   ////////////////////////////////////////////////////////////////////////////
   // Stage flow enables
   ////////////////////////////////////////////////////////////////////////////
   assign flow3 = exec_ready;
   assign flow2 = flow3;
   assign flow1 = flow2 & insn_ready_i;

   ncpu_fetch u_fetch (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .flow_i       (flow1),
      .dec_flow_i   (flow2),
      .jmp_i        (jmp),
      .jmp_offset_i (jmp_offset),
      .insn_i       (insn_i),
      .iaddr_o      (iaddr_o),
      .ibus_rd_o    (ibus_rd_o),
      .dec_insn_o   (dec_insn),
      .dec_valid_o  (dec_valid)
   );

   ncpu_decode u_decode (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .flow_i       (flow2),
      .insn_i       (dec_insn),
      .valid_i      (dec_valid),
      .rs1_addr_o   (rs1_addr),
      .rs2_addr_o   (rs2_addr),
      .jmp_o        (jmp),
      .jmp_offset_o (jmp_offset),
      .exec_op_o    (exec_op)
   );

   // Operands are read alongside the execute register load
   ncpu_regfile u_regfile (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .re_i       (flow2),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rs1_o      (rs1),
      .rs2_o      (rs2),
      .rd_we_i    (rd_we),
      .rd_addr_i  (rd_addr),
      .rd_i       (rd)
   );

   ncpu_execute u_execute (
      .exec_op_i       (exec_op),
      .rs1_i           (rs1),
      .rs2_i           (rs2),
      .d_i             (d_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .d_o             (d_o),
      .addr_o          (addr_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o),
      .ready_o         (exec_ready),
      .rd_we_o         (rd_we),
      .rd_addr_o       (rd_addr),
      .rd_o            (rd)
   );

endmodule

`default_nettype wire

// File: tb_ncpu_programs.svh
// Program table for the core testbench; include inside the testbench module after its helpers
`ifndef TB_NCPU_PROGRAMS_SVH
`define TB_NCPU_PROGRAMS_SVH

task automatic fill_program_table();
   // Logic ops, immediate extension rules
   add_insn(0, enc_i(ncpu_pkg::OP_ADD_I, 1, 0, 16'h1234));
   add_insn(0, enc_i(ncpu_pkg::OP_LSL_I, 1, 1, 16'd16));
   add_insn(0, enc_i(ncpu_pkg::OP_OR_I,  1, 1, 16'hF0F0));   // r1 = 1234F0F0
   add_insn(0, enc_i(ncpu_pkg::OP_ADD_I, 2, 0, 16'hFF00));
   add_insn(0, enc_r(ncpu_pkg::OP_AND,   3, 1, 2));
   add_insn(0, enc_i(ncpu_pkg::OP_STW,   3, 0, 16'h0000));
   add_insn(0, enc_r(ncpu_pkg::OP_OR,    4, 1, 2));
   add_insn(0, enc_i(ncpu_pkg::OP_STW,   4, 0, 16'h0004));
   add_insn(0, enc_r(ncpu_pkg::OP_XOR,   5, 1, 2));
   add_insn(0, enc_i(ncpu_pkg::OP_STW,   5, 0, 16'h0008));
   add_insn(0, enc_i(ncpu_pkg::OP_AND_I, 6, 1, 16'h8F0F));
   add_insn(0, enc_i(ncpu_pkg::OP_STW,   6, 0, 16'h000C));
   add_insn(0, enc_i(ncpu_pkg::OP_XOR_I, 7, 1, 16'h8001));
   add_insn(0, enc_i(ncpu_pkg::OP_STW,   7, 0, 16'h0010));
   add_insn(0, enc_i(ncpu_pkg::OP_OR_I,  8, 1, 16'h8001));
   add_insn(0, enc_i(ncpu_pkg::OP_STW,   8, 0, 16'h0014));
   add_halt(0);
   add_store(0, 32'h00, 32'h0000F000);
   add_store(0, 32'h04, 32'h1234FFF0);
   add_store(0, 32'h08, 32'h12340FF0);
   add_store(0, 32'h0C, 32'h12348000);
   add_store(0, 32'h10, 32'hEDCB70F1);
   add_store(0, 32'h14, 32'h1234F0F1);

   // Shifts and arithmetic on a negative operand
   add_insn(1, enc_i(ncpu_pkg::OP_ADD_I, 1, 0, 16'h8000));
   add_insn(1, enc_i(ncpu_pkg::OP_LSL_I, 1, 1, 16'd16));
   add_insn(1, enc_i(ncpu_pkg::OP_OR_I,  1, 1, 16'h0F01));   // r1 = 80000F01
   add_insn(1, enc_i(ncpu_pkg::OP_LSL_I, 2, 1, 16'd0));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,   2, 0, 16'h0000));
   add_insn(1, enc_i(ncpu_pkg::OP_LSL_I, 3, 1, 16'd1));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,   3, 0, 16'h0004));
   add_insn(1, enc_i(ncpu_pkg::OP_LSR_I, 4, 1, 16'd31));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,   4, 0, 16'h0008));
   add_insn(1, enc_i(ncpu_pkg::OP_ASR_I, 5, 1, 16'd1));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,   5, 0, 16'h000C));
   add_insn(1, enc_i(ncpu_pkg::OP_ASR_I, 6, 1, 16'd31));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,   6, 0, 16'h0010));
   add_insn(1, enc_i(ncpu_pkg::OP_ADD_I, 7, 0, 16'd31));
   add_insn(1, enc_r(ncpu_pkg::OP_LSL,   8, 1, 7));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,   8, 0, 16'h0014));
   add_insn(1, enc_r(ncpu_pkg::OP_ADD,  10, 6, 6));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,  10, 0, 16'h0018));
   add_insn(1, enc_r(ncpu_pkg::OP_SUB,  11, 0, 7));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,  11, 0, 16'h001C));
   add_insn(1, enc_i(ncpu_pkg::OP_ADD_I, 12, 6, 16'd2));
   add_insn(1, enc_i(ncpu_pkg::OP_STW,  12, 0, 16'h0020));
   add_insn(1, enc_r(ncpu_pkg::OP_LSR,  13, 1, 8));         // Shift amount is low 5 bits, zero
   add_insn(1, enc_i(ncpu_pkg::OP_STW,  13, 0, 16'h0024));
   add_halt(1);
   add_store(1, 32'h00, 32'h80000F01);
   add_store(1, 32'h04, 32'h00001E02);
   add_store(1, 32'h08, 32'h00000001);
   add_store(1, 32'h0C, 32'hC0000780);
   add_store(1, 32'h10, 32'hFFFFFFFF);
   add_store(1, 32'h14, 32'h80000000);
   add_store(1, 32'h18, 32'hFFFFFFFE);
   add_store(1, 32'h1C, 32'hFFFFFFE1);
   add_store(1, 32'h20, 32'h00000001);
   add_store(1, 32'h24, 32'h80000F01);

   // Store, load back, store again
   add_insn(2, enc_i(ncpu_pkg::OP_ADD_I, 1, 0, 16'h7ABC));
   add_insn(2, enc_i(ncpu_pkg::OP_LSL_I, 1, 1, 16'd16));
   add_insn(2, enc_i(ncpu_pkg::OP_OR_I,  1, 1, 16'h1357));
   add_insn(2, enc_i(ncpu_pkg::OP_STW,   1, 0, 16'h0040));
   add_insn(2, enc_i(ncpu_pkg::OP_LDWU,  2, 0, 16'h0040));
   add_insn(2, enc_i(ncpu_pkg::OP_STW,   2, 0, 16'h0044));
   add_insn(2, enc_i(ncpu_pkg::OP_ADD_I, 3, 0, 16'h0044));
   add_insn(2, enc_i(ncpu_pkg::OP_LDWU,  4, 3, 16'hFFFC));   // Negative offset
   add_insn(2, enc_i(ncpu_pkg::OP_STW,   4, 3, 16'h0004));
   add_halt(2);
   add_store(2, 32'h40, 32'h7ABC1357);
   add_store(2, 32'h44, 32'h7ABC1357);
   add_store(2, 32'h48, 32'h7ABC1357);

   // Jump with delay slot, the store at 0x0C is skipped
   add_insn(3, enc_i(ncpu_pkg::OP_ADD_I, 1, 0, 16'h0011));
   add_insn(3, enc_j(21'd2));
   add_insn(3, enc_i(ncpu_pkg::OP_ADD_I, 2, 0, 16'h0022));
   add_insn(3, enc_i(ncpu_pkg::OP_STW,   1, 0, 16'h0010));
   add_insn(3, enc_i(ncpu_pkg::OP_STW,   2, 0, 16'h0000));
   add_insn(3, enc_i(ncpu_pkg::OP_STW,   1, 0, 16'h0004));
   add_halt(3);
   add_store(3, 32'h00, 32'h00000022);
   add_store(3, 32'h04, 32'h00000011);
endtask

`endif

// File: tb_ncpu_core.sv
// Testbench for the core; runs each table program with and without instruction bus gaps
`timescale 1ns/1ps
`default_nettype none

module tb_ncpu_core;

   localparam int NPROG   = 4;
   localparam int MAXI    = 32;
   localparam int MAXS    = 16;
   localparam int TIMEOUT = 2000;         // Cycles allowed per wait

   logic                  clk_i = 1'b0;
   logic                  reset_i = 1'b0;
   logic                  insn_ready_i = 1'b0;
   logic                  dbus_rd_ready_i = 1'b0;
   logic                  dbus_we_done_i = 1'b0;
   ncpu_pkg::insn_t       insn_i;
   ncpu_pkg::data_t       d_i;
   ncpu_pkg::addr_t       iaddr_o;
   ncpu_pkg::addr_t       addr_o;
   ncpu_pkg::data_t       d_o;
   logic                  ibus_rd_o;
   logic                  dbus_rd_o;
   logic                  dbus_we_o;

   ncpu_pkg::insn_t       prog_mem [NPROG][MAXI];
   int                    prog_len [NPROG];
   ncpu_pkg::addr_t       exp_addr [NPROG][MAXS];
   ncpu_pkg::data_t       exp_data [NPROG][MAXS];
   int                    exp_cnt  [NPROG];
   ncpu_pkg::insn_t       imem [MAXI];
   ncpu_pkg::data_t       dmem [64];
   int                    cur_prog = 0;
   int                    store_idx = 0;
   bit                    gap_mode = 1'b0;
   int                    errors = 0;
   int                    checks = 0;

   always #2 clk_i = ~clk_i;

   // Memory models answer combinationally
   assign insn_i = (iaddr_o < 4 * MAXI) ? imem[iaddr_o[6:2]] : '0;
   assign d_i    = dmem[addr_o[7:2]];

   ncpu_core dut_i (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .insn_i          (insn_i),
      .insn_ready_i    (insn_ready_i),
      .iaddr_o         (iaddr_o),
      .ibus_rd_o       (ibus_rd_o),
      .d_i             (d_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .d_o             (d_o),
      .addr_o          (addr_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Encoding and table helpers
   ////////////////////////////////////////////////////////////////////////////
   function automatic ncpu_pkg::insn_t enc_r(input logic [5:0] op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
      return {11'b0, rs2, rs1, rd, op};
   endfunction

   function automatic ncpu_pkg::insn_t enc_i(input logic [5:0] op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [15:0] imm);
      return {imm, rs1, rd, op};
   endfunction

   function automatic ncpu_pkg::insn_t enc_j(input logic [20:0] rel);
      return {rel, 5'b0, 6'd18};           // Word offset from the delay slot
   endfunction

   task automatic add_insn(input int p, input ncpu_pkg::insn_t w);
      prog_mem[p][prog_len[p]] = w;
      prog_len[p]++;
   endtask

   task automatic add_halt(input int p);
      add_insn(p, enc_j(21'h1FFFFF));      // Jump to itself
      add_insn(p, '0);
   endtask

   task automatic add_store(input int p, input ncpu_pkg::addr_t a, input ncpu_pkg::data_t d);
      exp_addr[p][exp_cnt[p]] = a;
      exp_data[p][exp_cnt[p]] = d;
      exp_cnt[p]++;
   endtask

   `include "tb_ncpu_programs.svh"

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_idle(input logic ibus_exp);
      check_val("dbus_rd_o", dbus_rd_o, 1'b0);
      check_val("dbus_we_o", dbus_we_o, 1'b0);
      check_val("ibus_rd_o", ibus_rd_o, ibus_exp);
      check_val("iaddr_o", iaddr_o, ncpu_pkg::RESET_VECTOR);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus stimulus and store monitor
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge clk_i) begin
      insn_ready_i    <= gap_mode ? ($urandom % 4 != 0) : 1'b1;
      dbus_rd_ready_i <= ($urandom % 3 == 0);
      dbus_we_done_i  <= ($urandom % 3 == 0);
   end

   always @(posedge clk_i) begin
      if (!reset_i && dbus_we_o && dbus_we_done_i) begin
         dmem[addr_o[7:2]] <= d_o;
         if (store_idx >= exp_cnt[cur_prog]) begin
            $display("Unexpected extra store to %h in program %0d", addr_o, cur_prog);
            errors++;
         end else begin
            check_val("addr_o", addr_o, exp_addr[cur_prog][store_idx]);
            check_val("d_o", d_o, exp_data[cur_prog][store_idx]);
         end
         store_idx <= store_idx + 1;
      end
   end

   task automatic run_program(input int p, input bit gaps);
      int guard;
      cur_prog  = p;
      gap_mode  = gaps;
      store_idx <= 0;
      for (int i = 0; i < MAXI; i++) begin
         imem[i] = (i < prog_len[p]) ? prog_mem[p][i] : '0;
      end
      for (int i = 0; i < 64; i++) begin
         dmem[i] <= 32'hA5C30000 ^ (i * 4);   // Whole byte address in the fill
      end
      @(posedge clk_i);
      reset_i <= 1'b1;
      for (int c = 0; c < 8; c++) begin
         @(posedge clk_i);
         if (c == 7) reset_i <= 1'b0;
         @(negedge clk_i);
         check_idle(1'b0);
      end
      @(negedge clk_i);
      check_idle(1'b1);                     // First cycle out of reset
      guard = 0;
      while (store_idx < exp_cnt[p] && guard < TIMEOUT) begin
         @(posedge clk_i);
         guard++;
      end
      if (store_idx < exp_cnt[p]) begin
         $display("Timeout in program %0d: saw %0d of %0d stores", p, store_idx, exp_cnt[p]);
         errors++;
      end
      // Drain window to catch stores that should never happen
      for (int c = 0; c < 24; c++) begin
         @(posedge clk_i);
      end
   endtask

   initial begin
      void'($urandom(45));
      for (int p = 0; p < NPROG; p++) begin
         prog_len[p] = 0;
         exp_cnt[p]  = 0;
      end
      for (int i = 0; i < MAXI; i++) begin
         imem[i] = '0;
      end
      fill_program_table();
      for (int r = 0; r < 2 * NPROG; r++) begin
         run_program(r % NPROG, r >= NPROG);
      end
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
ncpu_pkg.sv
ncpu_fetch.sv
ncpu_decode.sv
ncpu_regfile.sv
ncpu_execute.sv
ncpu_core.sv
tb_ncpu_core.sv

// File: Bender.yml
package:
  name: ncpu

sources:
  - ncpu_pkg.sv
  - ncpu_fetch.sv
  - ncpu_decode.sv
  - ncpu_regfile.sv
  - ncpu_execute.sv
  - ncpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ncpu_core.sv
